//--- project.f
+incdir+verif
design/tdu_pkg.sv
design/tdu_csr_access.sv
design/tdu_trigger_bank.sv
design/tdu_match_unit.sv
design/tdu_top.sv
verif/tdu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the trigger unit testbench with Verilator and run it.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tdu_tb \
    -f project.f \
    -o tdu_tb_sim

./obj_dir/tdu_tb_sim

//--- verif/tdu_tb_model.svh
/*
 * Trigger unit reference model
 * Shadow TSELECT, trigger fields and TDATA2, expected CSR reads,
 * expected match vectors and debug-mode request
 */
`ifndef TDU_TB_MODEL_SVH
`define TDU_TB_MODEL_SVH

// Shadow state, advanced once per cycle by the compare process
int unsigned           sh_tsel;
mcontrol_s             sh_cfg    [TRIG_NUM];
logic [TDU_DATA_W-1:0] sh_tdata2 [TRIG_NUM];

function automatic void model_reset();
    sh_tsel = 0;
    for (int k = 0; k < TRIG_NUM; k++) begin
        sh_cfg[k]    = '0;
        sh_tdata2[k] = '0;
    end
endfunction

// Expected read data, zero without a request or for an unknown offset
function automatic logic [TDU_DATA_W-1:0] exp_read(input logic req, input csr_addr_e addr);
    logic [TDU_DATA_W-1:0] d;
    mcontrol_s             c;
    d = '0;
    c = sh_cfg[sh_tsel];
    if (req) begin
        case (addr)
            TSELECT: d = sh_tsel;
            TDATA1: begin
                // MCONTROL type 2, fixed fields zero
                d[31:28] = 4'd2;
                d[20]    = c.hit;
                d[12]    = c.action;
                d[6]     = c.m;
                d[2]     = c.exec;
                d[1]     = c.store;
                d[0]     = c.load;
            end
            TDATA2: d = sh_tdata2[sh_tsel];
            TINFO: d[2] = 1'b1;
            default: d = '0;
        endcase
    end
    return d;
endfunction

// Execute address match per trigger
function automatic logic [TRIG_NUM-1:0] exp_imatch(input imon_s mon);
    logic [TRIG_NUM-1:0] v;
    for (int k = 0; k < TRIG_NUM; k++) begin
        v[k] = sh_cfg[k].m & sh_cfg[k].exec & mon.vd & (mon.addr == sh_tdata2[k]);
    end
    return v;
endfunction

// Load/store address match per trigger
function automatic logic [TRIG_NUM-1:0] exp_dmatch(input dmon_s mon);
    logic [TRIG_NUM-1:0] v;
    for (int k = 0; k < TRIG_NUM; k++) begin
        v[k] = sh_cfg[k].m & mon.vd & (mon.addr == sh_tdata2[k])
             & ((sh_cfg[k].load & mon.load) | (sh_cfg[k].store & mon.store));
    end
    return v;
endfunction

function automatic logic exp_dmode(input logic [TRIG_NUM-1:0] retire);
    logic r;
    r = 1'b0;
    for (int k = 0; k < TRIG_NUM; k++) begin
        r = r | (sh_cfg[k].action & retire[k]);
    end
    return r;
endfunction

// State change at the coming rising edge
function automatic void model_commit(input logic req, input csr_cmd_e cmd,
                                     input csr_addr_e addr, input logic [TDU_DATA_W-1:0] wdata,
                                     input logic [TRIG_NUM-1:0] retire);
    logic [TDU_DATA_W-1:0] rd;
    logic [TDU_DATA_W-1:0] val;
    logic                  wr;
    logic [TRIG_NUM-1:0]   t1wr;
    rd   = exp_read(req, addr);
    t1wr = '0;
    // Set and clear with a zero operand leave everything alone
    wr = req & ((cmd == CSR_CMD_WRITE)
         | (((cmd == CSR_CMD_SET) | (cmd == CSR_CMD_CLEAR)) & (wdata != '0)));
    if (cmd == CSR_CMD_WRITE) begin
        val = wdata;
    end else if (cmd == CSR_CMD_SET) begin
        val = rd | wdata;
    end else begin
        val = rd & ~wdata;
    end
    if (wr) begin
        case (addr)
            TSELECT: begin
                if (val < TRIG_NUM) begin
                    sh_tsel = val;
                end
            end
            TDATA1: begin
                sh_cfg[sh_tsel].m      = val[6];
                sh_cfg[sh_tsel].exec   = val[2];
                sh_cfg[sh_tsel].load   = val[0];
                sh_cfg[sh_tsel].store  = val[1];
                sh_cfg[sh_tsel].action = (val[17:12] == 6'd1);
                sh_cfg[sh_tsel].hit    = val[20];
                t1wr[sh_tsel]          = 1'b1;
            end
            TDATA2: sh_tdata2[sh_tsel] = val;
            default: ;
        endcase
    end
    // Retire sets hit unless TDATA1 is written in the same cycle
    for (int k = 0; k < TRIG_NUM; k++) begin
        if (retire[k] && !t1wr[k]) begin
            sh_cfg[k].hit = 1'b1;
        end
    end
endfunction

`endif

//--- verif/tdu_tb.sv
/*
 * Trigger unit testbench
 * CSR register access, random execute and load/store monitor traffic,
 * retire and debug-mode request, all checked against a shadow model
 */
module tdu_tb;
    import tdu_pkg::*;

    localparam int TRIG_NUM     = 2;
    localparam int CLK_PERIOD   = 40;
    localparam int RESP_TIMEOUT = 8;
    localparam int RUN_LIMIT    = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  csr_req_i;
    csr_cmd_e              csr_cmd_i;
    csr_addr_e             csr_addr_i;
    logic [TDU_DATA_W-1:0] csr_wdata_i;
    logic [TDU_DATA_W-1:0] csr_rdata_o;
    csr_resp_e             csr_resp_o;
    imon_s                 imon_i;
    dmon_s                 dmon_i;
    logic [TRIG_NUM-1:0]   bp_retire_i;
    logic [TRIG_NUM-1:0]   ibrkpt_match_o;
    logic [TRIG_NUM-1:0]   dbrkpt_match_o;
    logic                  ibrkpt_exc_req_o;
    logic                  dbrkpt_exc_req_o;
    logic                  dmode_req_o;
    int                    seed;

    `include "tdu_tb_model.svh"

    tdu_top #(
        .TRIG_NUM (TRIG_NUM)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .csr_req_i        (csr_req_i),
        .csr_cmd_i        (csr_cmd_i),
        .csr_addr_i       (csr_addr_i),
        .csr_wdata_i      (csr_wdata_i),
        .csr_rdata_o      (csr_rdata_o),
        .csr_resp_o       (csr_resp_o),
        .imon_i           (imon_i),
        .dmon_i           (dmon_i),
        .bp_retire_i      (bp_retire_i),
        .ibrkpt_match_o   (ibrkpt_match_o),
        .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
        .dbrkpt_match_o   (dbrkpt_match_o),
        .dbrkpt_exc_req_o (dbrkpt_exc_req_o),
        .dmode_req_o      (dmode_req_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //--------------------------------------------------
    // Failure and compare helpers
    //--------------------------------------------------
    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [TDU_DATA_W-1:0] got,
                              input logic [TDU_DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input csr_resp_e got, input csr_resp_e exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_vec(input string name, input logic [TRIG_NUM-1:0] got,
                             input logic [TRIG_NUM-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Quarter period after the falling edge, inputs have settled
    always @(negedge clk) begin
        #(CLK_PERIOD / 4);
        if (!rst_n) begin
            model_reset();
        end else begin
            check_word("csr_rdata_o", csr_rdata_o, exp_read(csr_req_i, csr_addr_i));
            check_resp("csr_resp_o", csr_resp_o, csr_req_i ? CSR_RESP_OK : CSR_RESP_ER);
            check_vec("ibrkpt_match_o", ibrkpt_match_o, exp_imatch(imon_i));
            check_bit("ibrkpt_exc_req_o", ibrkpt_exc_req_o, |exp_imatch(imon_i));
            check_vec("dbrkpt_match_o", dbrkpt_match_o, exp_dmatch(dmon_i));
            check_bit("dbrkpt_exc_req_o", dbrkpt_exc_req_o, |exp_dmatch(dmon_i));
            check_bit("dmode_req_o", dmode_req_o, exp_dmode(bp_retire_i));
            model_commit(csr_req_i, csr_cmd_i, csr_addr_i, csr_wdata_i, bp_retire_i);
        end
    end

    //--------------------------------------------------
    // Stimulus tasks, all driving on the falling edge
    //--------------------------------------------------
    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            csr_req_i   = 1'b0;
            csr_cmd_i   = CSR_CMD_NONE;
            csr_wdata_i = '0;
            imon_i      = '0;
            dmon_i      = '0;
            bp_retire_i = '0;
        end
    endtask

    // One-cycle CSR request with a retire vector in the same cycle
    task automatic csr_op_retire(input csr_cmd_e cmd, input csr_addr_e addr,
                                 input logic [TDU_DATA_W-1:0] wdata,
                                 input logic [TRIG_NUM-1:0] retire);
        int steps;
        @(negedge clk);
        csr_req_i   = 1'b1;
        csr_cmd_i   = cmd;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        bp_retire_i = retire;
        steps       = 0;
        #1;
        while (csr_resp_o !== CSR_RESP_OK && steps < RESP_TIMEOUT) begin
            steps++;
            #1;
        end
        if (csr_resp_o !== CSR_RESP_OK) begin
            fail_stop("CSR request was not answered with an OK response in time");
        end
        @(negedge clk);
        csr_req_i   = 1'b0;
        csr_cmd_i   = CSR_CMD_NONE;
        csr_wdata_i = '0;
        bp_retire_i = '0;
    endtask

    // One-cycle CSR request, released on the next falling edge
    task automatic csr_op(input csr_cmd_e cmd, input csr_addr_e addr,
                          input logic [TDU_DATA_W-1:0] wdata);
        csr_op_retire(cmd, addr, wdata, '0);
    endtask

    // Half the addresses hit a programmed TDATA2
    task automatic drive_imon();
        logic [31:0] r;
        int          k;
        @(negedge clk);
        r           = rand_word();
        k           = int'(r[31:30]) % TRIG_NUM;
        imon_i.vd   = r[0] | r[1];
        imon_i.addr = r[2] ? sh_tdata2[k] : rand_word();
    endtask

    task automatic drive_dmon();
        logic [31:0] r;
        int          k;
        @(negedge clk);
        r            = rand_word();
        k            = int'(r[31:30]) % TRIG_NUM;
        dmon_i.vd    = r[0] | r[1];
        dmon_i.load  = r[3];
        dmon_i.store = r[4];
        dmon_i.addr  = r[2] ? sh_tdata2[k] : rand_word();
    endtask

    task automatic pulse_retire(input logic [TRIG_NUM-1:0] v);
        @(negedge clk);
        bp_retire_i = v;
        @(negedge clk);
        bp_retire_i = '0;
    endtask

    // Hard limit on the whole run
    initial begin
        #(CLK_PERIOD * RUN_LIMIT);
        fail_stop("Simulation did not reach the end within the time limit");
    end

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        logic [TRIG_NUM-1:0] onehot;
        seed        = 32'h5c93fef2;
        rst_n       = 1'b0;
        csr_req_i   = 1'b0;
        csr_cmd_i   = CSR_CMD_NONE;
        csr_addr_i  = TSELECT;
        csr_wdata_i = '0;
        imon_i      = '0;
        dmon_i      = '0;
        bp_retire_i = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Reset values, idle response and unknown offset
        idle(2);
        csr_op(CSR_CMD_NONE, TSELECT, '0);
        csr_op(CSR_CMD_NONE, TDATA1, '0);
        csr_op(CSR_CMD_NONE, TDATA2, '0);
        csr_op(CSR_CMD_NONE, TINFO, '0);
        csr_op(CSR_CMD_NONE, csr_addr_e'(3'd3), '0);

        // TSELECT range check
        csr_op(CSR_CMD_WRITE, TSELECT, 32'd1);
        csr_op(CSR_CMD_NONE, TSELECT, '0);
        csr_op(CSR_CMD_WRITE, TSELECT, 32'(TRIG_NUM));
        csr_op(CSR_CMD_WRITE, TSELECT, rand_word() | 32'h8000_0000);
        csr_op(CSR_CMD_NONE, TSELECT, '0);

        // Per-trigger registers, then enable every match kind
        for (int k = 0; k < TRIG_NUM; k++) begin
            onehot    = '0;
            onehot[k] = 1'b1;
            csr_op(CSR_CMD_WRITE, TSELECT, 32'(k));
            csr_op(CSR_CMD_WRITE, TDATA1, rand_word());
            csr_op(CSR_CMD_NONE, TDATA1, '0);
            csr_op(CSR_CMD_SET, TDATA1, rand_word());
            csr_op(CSR_CMD_CLEAR, TDATA1, rand_word());
            // Retire next to a zero-operand SET or CLEAR still sets hit
            csr_op(CSR_CMD_CLEAR, TDATA1, 32'h0010_0000);
            csr_op_retire(CSR_CMD_SET, TDATA1, '0, onehot);
            csr_op(CSR_CMD_CLEAR, TDATA1, 32'h0010_0000);
            csr_op_retire(CSR_CMD_CLEAR, TDATA1, '0, onehot);
            csr_op(CSR_CMD_NONE, TDATA1, '0);
            csr_op(CSR_CMD_WRITE, TDATA2, rand_word());
            csr_op(CSR_CMD_SET, TDATA2, rand_word());
            csr_op(CSR_CMD_CLEAR, TDATA2, rand_word());
            csr_op(CSR_CMD_CLEAR, TDATA2, '0);
            // Trigger 0 enters debug mode on any access
            // Others use action 2 and watch loads only
            csr_op(CSR_CMD_WRITE, TDATA1, (k == 0) ? 32'h0000_1047 : 32'h0000_2045);
            csr_op(CSR_CMD_WRITE, TDATA2, rand_word() & 32'hffff_fffc);
            csr_op(CSR_CMD_NONE, TINFO, '0);
        end

        // Instruction and data monitors
        repeat (40) drive_imon();
        idle(1);
        repeat (40) drive_dmon();
        idle(1);

        // Trigger 1 with M cleared must stay quiet
        csr_op(CSR_CMD_WRITE, TSELECT, 32'd1);
        csr_op(CSR_CMD_CLEAR, TDATA1, 32'h0000_0040);
        repeat (10) drive_imon();
        repeat (10) drive_dmon();
        csr_op(CSR_CMD_SET, TDATA1, 32'h0000_0040);
        idle(1);

        // Retire sets hit, dmode only for action 1
        for (int k = 0; k < TRIG_NUM; k++) begin
            onehot    = '0;
            onehot[k] = 1'b1;
            pulse_retire(onehot);
            csr_op(CSR_CMD_WRITE, TSELECT, 32'(k));
            csr_op(CSR_CMD_NONE, TDATA1, '0);
            csr_op(CSR_CMD_CLEAR, TDATA1, 32'h0010_0000);
        end
        pulse_retire('1);
        csr_op(CSR_CMD_NONE, TDATA1, '0);
        idle(2);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- design/tdu_top.sv
/*
 * Trigger unit top
 * CSR access, trigger bank and match unit for TRIG_NUM breakpoints
 */
module tdu_top #(
    parameter int unsigned TRIG_NUM = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // CSR port
    input  logic                            csr_req_i,
    input  tdu_pkg::csr_cmd_e               csr_cmd_i,
    input  tdu_pkg::csr_addr_e              csr_addr_i,
    input  logic [tdu_pkg::TDU_DATA_W-1:0]  csr_wdata_i,
    output logic [tdu_pkg::TDU_DATA_W-1:0]  csr_rdata_o,
    output tdu_pkg::csr_resp_e              csr_resp_o,
    // Execute and load/store monitors
    input  tdu_pkg::imon_s                  imon_i,
    input  tdu_pkg::dmon_s                  dmon_i,
    input  logic [TRIG_NUM-1:0]             bp_retire_i,
    // Match and request outputs
    output logic [TRIG_NUM-1:0]             ibrkpt_match_o,
    output logic                            ibrkpt_exc_req_o,
    output logic [TRIG_NUM-1:0]             dbrkpt_match_o,
    output logic                            dbrkpt_exc_req_o,
    output logic                            dmode_req_o
);
    import tdu_pkg::*;

    localparam int unsigned TSEL_W = (TRIG_NUM > 1) ? $clog2(TRIG_NUM) : 1;

    // Bank state
    logic [TSEL_W-1:0]                    tselect;
    mcontrol_s [TRIG_NUM-1:0]             trig_cfg;
    logic [TRIG_NUM-1:0][TDU_DATA_W-1:0]  tdata2;

    // Write path into the bank
    logic [TDU_DATA_W-1:0]                wr_data;
    logic                                 tselect_wr;
    logic [TRIG_NUM-1:0]                  tdata1_wr;
    logic [TRIG_NUM-1:0]                  tdata2_wr;

    tdu_csr_access #(
        .TRIG_NUM (TRIG_NUM)
    ) u_csr_access (
        .csr_req_i    (csr_req_i),
        .csr_cmd_i    (csr_cmd_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .tselect_i    (tselect),
        .trig_cfg_i   (trig_cfg),
        .tdata2_i     (tdata2),
        .csr_rdata_o  (csr_rdata_o),
        .csr_resp_o   (csr_resp_o),
        .wr_data_o    (wr_data),
        .tselect_wr_o (tselect_wr),
        .tdata1_wr_o  (tdata1_wr),
        .tdata2_wr_o  (tdata2_wr)
    );

    tdu_trigger_bank #(
        .TRIG_NUM (TRIG_NUM)
    ) u_trigger_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_data_i    (wr_data),
        .tselect_wr_i (tselect_wr),
        .tdata1_wr_i  (tdata1_wr),
        .tdata2_wr_i  (tdata2_wr),
        .bp_retire_i  (bp_retire_i),
        .tselect_o    (tselect),
        .trig_cfg_o   (trig_cfg),
        .tdata2_o     (tdata2)
    );

    tdu_match_unit #(
        .TRIG_NUM (TRIG_NUM)
    ) u_match_unit (
        .imon_i           (imon_i),
        .dmon_i           (dmon_i),
        .bp_retire_i      (bp_retire_i),
        .trig_cfg_i       (trig_cfg),
        .tdata2_i         (tdata2),
        .ibrkpt_match_o   (ibrkpt_match_o),
        .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
        .dbrkpt_match_o   (dbrkpt_match_o),
        .dbrkpt_exc_req_o (dbrkpt_exc_req_o),
        .dmode_req_o      (dmode_req_o)
    );

endmodule

//--- design/tdu_match_unit.sv
/*
 * Trigger match unit
 * Per-trigger execute and load/store address compare, exception
 * requests and debug-mode request on retire
 */
module tdu_match_unit #(
    parameter int unsigned TRIG_NUM = 2
) (
    input  tdu_pkg::imon_s                                imon_i,
    input  tdu_pkg::dmon_s                                dmon_i,
    input  logic [TRIG_NUM-1:0]                           bp_retire_i,
    input  tdu_pkg::mcontrol_s [TRIG_NUM-1:0]             trig_cfg_i,
    input  logic [TRIG_NUM-1:0][tdu_pkg::TDU_DATA_W-1:0]  tdata2_i,
    output logic [TRIG_NUM-1:0]                           ibrkpt_match_o,
    output logic                                          ibrkpt_exc_req_o,
    output logic [TRIG_NUM-1:0]                           dbrkpt_match_o,
    output logic                                          dbrkpt_exc_req_o,
    output logic                                          dmode_req_o
);
    logic [TRIG_NUM-1:0] action_vec;

    //------------------------------------------------
    // Comparators
    //------------------------------------------------
    for (genvar k = 0; k < TRIG_NUM; k++) begin : g_cmp
        // Instruction breakpoint, needs M enable and execute
        assign ibrkpt_match_o[k] = trig_cfg_i[k].m & trig_cfg_i[k].exec & imon_i.vd
                                 & (imon_i.addr == tdata2_i[k]);

        // Watchpoint on a load or a store of the enabled kind
        assign dbrkpt_match_o[k] = trig_cfg_i[k].m & dmon_i.vd
                                 & ((trig_cfg_i[k].load & dmon_i.load)
                                  | (trig_cfg_i[k].store & dmon_i.store))
                                 & (dmon_i.addr == tdata2_i[k]);

        assign action_vec[k] = trig_cfg_i[k].action;
    end

    // Any hit raises the exception
    assign ibrkpt_exc_req_o = |ibrkpt_match_o;
    assign dbrkpt_exc_req_o = |dbrkpt_match_o;

    // Debug entry only for retiring triggers with action 1
    assign dmode_req_o = |(action_vec & bp_retire_i);

endmodule

//--- design/tdu_trigger_bank.sv
/*
 * Trigger register bank
 * TSELECT with range check, per-trigger MCONTROL fields and TDATA2,
 * sticky hit flag set on breakpoint retire
 */
module tdu_trigger_bank #(
    parameter int unsigned  TRIG_NUM = 2,
    localparam int unsigned TSEL_W   = (TRIG_NUM > 1) ? $clog2(TRIG_NUM) : 1
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [tdu_pkg::TDU_DATA_W-1:0]                wr_data_i,
    input  logic                                          tselect_wr_i,
    input  logic [TRIG_NUM-1:0]                           tdata1_wr_i,
    input  logic [TRIG_NUM-1:0]                           tdata2_wr_i,
    input  logic [TRIG_NUM-1:0]                           bp_retire_i,
    output logic [TSEL_W-1:0]                             tselect_o,
    output tdu_pkg::mcontrol_s [TRIG_NUM-1:0]             trig_cfg_o,
    output logic [TRIG_NUM-1:0][tdu_pkg::TDU_DATA_W-1:0]  tdata2_o
);
    import tdu_pkg::*;

    logic      tselect_ok;
    mcontrol_s wr_cfg;

    //------------------------------------------------
    // TSELECT
    //------------------------------------------------
    // Out-of-range index is dropped, old value kept
    assign tselect_ok = (wr_data_i < TDU_DATA_W'(TRIG_NUM));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tselect_o <= '0;
        end else if (tselect_wr_i && tselect_ok) begin
            tselect_o <= wr_data_i[TSEL_W-1:0];
        end
    end

    //------------------------------------------------
    // TDATA1 write decode
    //------------------------------------------------
    // Same decode for every trigger
    always_comb begin
        wr_cfg.m      = wr_data_i[MCONTROL_M];
        wr_cfg.exec   = wr_data_i[MCONTROL_EXECUTE];
        wr_cfg.load   = wr_data_i[MCONTROL_LOAD];
        wr_cfg.store  = wr_data_i[MCONTROL_STORE];
        // Only action 1 (enter debug mode) is remembered
        wr_cfg.action = (wr_data_i[MCONTROL_ACTION_HI:MCONTROL_ACTION_LO] == 6'd1);
        wr_cfg.hit    = wr_data_i[MCONTROL_HIT];
    end

    //------------------------------------------------
    // Per-trigger registers
    //------------------------------------------------
    for (genvar k = 0; k < TRIG_NUM; k++) begin : g_trig
        // CSR write wins over a retire in the same cycle
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                trig_cfg_o[k] <= '0;
            end else if (tdata1_wr_i[k]) begin
                trig_cfg_o[k] <= wr_cfg;
            end else if (bp_retire_i[k]) begin
                trig_cfg_o[k].hit <= 1'b1;
            end
        end

        // Match address
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tdata2_o[k] <= '0;
            end else if (tdata2_wr_i[k]) begin
                tdata2_o[k] <= wr_data_i;
            end
        end
    end

endmodule

//--- design/tdu_csr_access.sv
/*
 * Trigger unit CSR access
 * Same-cycle read mux and response, set/clear resolution against the
 * read value, and write strobes toward the trigger bank
 */
module tdu_csr_access #(
    parameter int unsigned  TRIG_NUM = 2,
    localparam int unsigned TSEL_W   = (TRIG_NUM > 1) ? $clog2(TRIG_NUM) : 1
) (
    input  logic                                          csr_req_i,
    input  tdu_pkg::csr_cmd_e                             csr_cmd_i,
    input  tdu_pkg::csr_addr_e                            csr_addr_i,
    input  logic [tdu_pkg::TDU_DATA_W-1:0]                csr_wdata_i,
    input  logic [TSEL_W-1:0]                             tselect_i,
    input  tdu_pkg::mcontrol_s [TRIG_NUM-1:0]             trig_cfg_i,
    input  logic [TRIG_NUM-1:0][tdu_pkg::TDU_DATA_W-1:0]  tdata2_i,
    output logic [tdu_pkg::TDU_DATA_W-1:0]                csr_rdata_o,
    output tdu_pkg::csr_resp_e                            csr_resp_o,
    output logic [tdu_pkg::TDU_DATA_W-1:0]                wr_data_o,
    output logic                                          tselect_wr_o,
    output logic [TRIG_NUM-1:0]                           tdata1_wr_o,
    output logic [TRIG_NUM-1:0]                           tdata2_wr_o
);
    import tdu_pkg::*;

    logic [TDU_DATA_W-1:0] rdata;
    logic                  wr_req;

    //------------------------------------------------
    // Read side
    //------------------------------------------------
    // Any request is accepted
    assign csr_resp_o = csr_req_i ? CSR_RESP_OK : CSR_RESP_ER;

    always_comb begin
        rdata = '0;
        if (csr_req_i) begin
            case (csr_addr_i)
                TSELECT: begin
                    rdata = TDU_DATA_W'(tselect_i);
                end
                TDATA1: begin
                    for (int k = 0; k < TRIG_NUM; k++) begin
                        if (tselect_i == TSEL_W'(k)) begin
                            // Fixed fields first
                            rdata[TDATA1_TYPE_HI:TDATA1_TYPE_LO] = MCONTROL_TYPE_VAL;
                            rdata[TDATA1_DMODE]                  = 1'b0;
                            rdata[MCONTROL_MASKMAX_HI:MCONTROL_MASKMAX_LO] = '0;
                            rdata[MCONTROL_SELECT]               = 1'b0;
                            rdata[MCONTROL_TIMING]               = 1'b0;
                            rdata[MCONTROL_CHAIN]                = 1'b0;
                            rdata[MCONTROL_MATCH_HI:MCONTROL_MATCH_LO] = '0;
                            rdata[MCONTROL_S]                    = 1'b0;
                            rdata[MCONTROL_U]                    = 1'b0;
                            // Stored fields of the selected trigger
                            rdata[MCONTROL_HIT]     = trig_cfg_i[k].hit;
                            rdata[MCONTROL_ACTION_HI:MCONTROL_ACTION_LO] =
                                {5'b0, trig_cfg_i[k].action};
                            rdata[MCONTROL_M]       = trig_cfg_i[k].m;
                            rdata[MCONTROL_EXECUTE] = trig_cfg_i[k].exec;
                            rdata[MCONTROL_STORE]   = trig_cfg_i[k].store;
                            rdata[MCONTROL_LOAD]    = trig_cfg_i[k].load;
                        end
                    end
                end
                TDATA2: begin
                    for (int k = 0; k < TRIG_NUM; k++) begin
                        if (tselect_i == TSEL_W'(k)) begin
                            rdata = tdata2_i[k];
                        end
                    end
                end
                TINFO: begin
                    for (int k = 0; k < TRIG_NUM; k++) begin
                        if (tselect_i == TSEL_W'(k)) begin
                            rdata[TINFO_MCONTROL_BIT] = 1'b1;
                        end
                    end
                end
                default: begin
                    rdata = '0;
                end
            endcase
        end
    end

    assign csr_rdata_o = rdata;

    //------------------------------------------------
    // Write side
    //------------------------------------------------
    // Set and clear with a zero operand are no-ops
    always_comb begin
        wr_req    = 1'b0;
        wr_data_o = '0;
        case (csr_cmd_i)
            CSR_CMD_WRITE: begin
                wr_req    = 1'b1;
                wr_data_o = csr_wdata_i;
            end
            CSR_CMD_SET: begin
                wr_req    = |csr_wdata_i;
                wr_data_o = rdata | csr_wdata_i;
            end
            CSR_CMD_CLEAR: begin
                wr_req    = |csr_wdata_i;
                wr_data_o = rdata & ~csr_wdata_i;
            end
            default: begin
                wr_req = 1'b0;
            end
        endcase
    end

    assign tselect_wr_o = csr_req_i & wr_req & (csr_addr_i == TSELECT);

    // One-hot strobes on the currently selected trigger
    always_comb begin
        tdata1_wr_o = '0;
        tdata2_wr_o = '0;
        for (int k = 0; k < TRIG_NUM; k++) begin
            if (tselect_i == TSEL_W'(k)) begin
                tdata1_wr_o[k] = csr_req_i & wr_req & (csr_addr_i == TDATA1);
                tdata2_wr_o[k] = csr_req_i & wr_req & (csr_addr_i == TDATA2);
            end
        end
    end

endmodule

//--- design/tdu_pkg.sv
/*
 * Trigger unit shared definitions
 * Data width, MCONTROL field layout of TDATA1, CSR command, response
 * and address enums, monitor and per-trigger config structs
 */
package tdu_pkg;

    // CSR word and monitored address width, layout below assumes 32
    localparam int unsigned TDU_DATA_W = 32;

    //------------------------------------------------
    // TDATA1 field positions, MCONTROL layout
    //------------------------------------------------
    localparam int unsigned TDATA1_TYPE_HI       = 31;
    localparam int unsigned TDATA1_TYPE_LO       = 28;
    localparam int unsigned TDATA1_DMODE         = 27;
    localparam int unsigned MCONTROL_MASKMAX_HI  = 26;
    localparam int unsigned MCONTROL_MASKMAX_LO  = 21;
    localparam int unsigned MCONTROL_HIT         = 20;
    localparam int unsigned MCONTROL_SELECT      = 19;
    localparam int unsigned MCONTROL_TIMING      = 18;
    localparam int unsigned MCONTROL_ACTION_HI   = 17;
    localparam int unsigned MCONTROL_ACTION_LO   = 12;
    localparam int unsigned MCONTROL_CHAIN       = 11;
    localparam int unsigned MCONTROL_MATCH_HI    = 10;
    localparam int unsigned MCONTROL_MATCH_LO    = 7;
    localparam int unsigned MCONTROL_M           = 6;
    // Bit 5 reserved, reads zero
    localparam int unsigned MCONTROL_S           = 4;
    localparam int unsigned MCONTROL_U           = 3;
    localparam int unsigned MCONTROL_EXECUTE     = 2;
    localparam int unsigned MCONTROL_STORE       = 1;
    localparam int unsigned MCONTROL_LOAD        = 0;

    // Type field value of an address/data match trigger
    localparam logic [3:0] MCONTROL_TYPE_VAL = 4'd2;

    // TINFO bit advertising MCONTROL support
    localparam int unsigned TINFO_MCONTROL_BIT = 2;

    //------------------------------------------------
    // CSR port encodings
    //------------------------------------------------
    typedef enum logic [1:0] {
        CSR_CMD_NONE  = 2'd0,
        CSR_CMD_WRITE = 2'd1,
        CSR_CMD_SET   = 2'd2,
        CSR_CMD_CLEAR = 2'd3
    } csr_cmd_e;

    typedef enum logic {
        CSR_RESP_OK = 1'b0,
        CSR_RESP_ER = 1'b1
    } csr_resp_e;

    // Register offsets inside the trigger CSR window
    typedef enum logic [2:0] {
        TSELECT = 3'd0,
        TDATA1  = 3'd1,
        TDATA2  = 3'd2,
        TINFO   = 3'd4
    } csr_addr_e;

    //------------------------------------------------
    // Monitor and config structs
    //------------------------------------------------
    // Instruction fetch/execute address stream
    typedef struct packed {
        logic                  vd;
        logic [TDU_DATA_W-1:0] addr;
    } imon_s;

    // Load/store address stream
    typedef struct packed {
        logic                  vd;
        logic                  load;
        logic                  store;
        logic [TDU_DATA_W-1:0] addr;
    } dmon_s;

    // Stored state of one trigger, action kept as "action == 1"
    typedef struct packed {
        logic m;
        logic exec;
        logic load;
        logic store;
        logic action;
        logic hit;
    } mcontrol_s;

endpackage
